//--- logic/pcx_stall_config.svh
// Sizing, threshold and seed macros for the PCX stall injector, included by RTL and testbench
`ifndef PCX_STALL_CONFIG_SVH
`define PCX_STALL_CONFIG_SVH

// L2 bank destinations, plus the FPU/IOB port as the last destination
`define PCX_NUM_BANKS 4
`define PCX_NUM_DEST 5

// L2 input-queue count width and the level below which a bank may be stalled
`define PCX_QCNT_W 5
`define PCX_IQ_THRESHOLD 10

// Phase counter width, also the width of min_stall and win_mask
`define PCX_PHASE_W 8

// Random configuration after reset
`define PCX_MIN_STALL_RST 8'd1
`define PCX_WIN_MASK_RST 8'h7F

// Per-timer LFSR reset seeds, all nonzero so no timer locks up
`define PCX_LFSR_SEED0 16'hACE1
`define PCX_LFSR_SEED1 16'h5A3C
`define PCX_LFSR_SEED2 16'hB791
`define PCX_LFSR_SEED3 16'h1F2E
`define PCX_LFSR_SEED4 16'hC46D

`endif

//--- logic/pcx_stall_pkg.sv
// Shared command, configuration and timer types of the PCX stall injector, imported by its modules
`include "pcx_stall_config.svh"

package pcx_stall_pkg;

    // Software commands carried on the cmd port when cmd_valid is high
    typedef enum logic [2:0] {
        OP_NOP        = 3'd0,
        OP_STALL_ON   = 3'd1,
        OP_FREE_ON    = 3'd2,
        OP_SET_WINDOW = 3'd3,
        OP_RANDOM_EN  = 3'd4
    } stall_opcode_e;

    // Free/stall phase of one random interval timer
    typedef enum logic {
        PH_FREE  = 1'b0,
        PH_STALL = 1'b1
    } timer_phase_e;

    // bank_mask selects banks for STALL_ON/FREE_ON, bit 0 is the enable for RANDOM_EN
    typedef struct packed {
        stall_opcode_e                opcode;
        logic [`PCX_NUM_BANKS-1:0]    bank_mask;
        logic [`PCX_PHASE_W-1:0]      min_stall;
        logic [`PCX_PHASE_W-1:0]      win_mask;
    } stall_cmd_t;

    // Random stall configuration shared by all five timers
    typedef struct packed {
        logic                         rand_en;
        logic [`PCX_PHASE_W-1:0]      min_stall;
        logic [`PCX_PHASE_W-1:0]      win_mask;
    } stall_cfg_t;

    // One input-queue count per L2 bank, index 0 is bank 0
    typedef logic [`PCX_NUM_BANKS-1:0][`PCX_QCNT_W-1:0] bank_qcnt_t;

endpackage

//--- logic/stall_cmd_decode.sv
// Command decoder that keeps the held-stall masks and the random-stall configuration registers
`timescale 1ns/1ps
`include "pcx_stall_config.svh"

module stall_cmd_decode
    import pcx_stall_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cmd_valid,
    input  stall_cmd_t                cmd,
    output logic [`PCX_NUM_BANKS-1:0] held_stall,
    output stall_cfg_t                cfg
);

    logic [`PCX_NUM_BANKS-1:0] set_mask;
    logic [`PCX_NUM_BANKS-1:0] clr_mask;
    logic                      load_window;
    logic                      load_enable;

    // Only one opcode is active per command, so set and clear come from separate commands
    // unless the same cycle carries both through a later extension
    always_comb begin
        set_mask    = '0;
        clr_mask    = '0;
        load_window = 1'b0;
        load_enable = 1'b0;
        if (cmd_valid) begin
            case (cmd.opcode)
                OP_STALL_ON:   set_mask    = cmd.bank_mask;
                OP_FREE_ON:    clr_mask    = cmd.bank_mask;
                OP_SET_WINDOW: load_window = 1'b1;
                OP_RANDOM_EN:  load_enable = 1'b1;
                default: begin
                end
            endcase
        end
    end

    // Release has priority over hold on the same bank
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            held_stall <= '0;
        end else begin
            held_stall <= (held_stall | set_mask) & ~clr_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg.rand_en   <= 1'b0;
            cfg.min_stall <= `PCX_MIN_STALL_RST;
            cfg.win_mask  <= `PCX_WIN_MASK_RST;
        end else begin
            if (load_window) begin
                cfg.min_stall <= cmd.min_stall;
                cfg.win_mask  <= cmd.win_mask;
            end
            if (load_enable) begin
                cfg.rand_en <= cmd.bank_mask[0];
            end
        end
    end

endmodule

//--- logic/stall_interval_timer.sv
// LFSR-driven free/stall phase timer that produces the random stall level of one destination
`timescale 1ns/1ps
`include "pcx_stall_config.svh"

module stall_interval_timer
    import pcx_stall_pkg::*;
#(
    parameter logic [15:0] SEED = `PCX_LFSR_SEED0
) (
    input  logic       clk,
    input  logic       rst_n,
    input  stall_cfg_t cfg,
    output logic       rand_stall
);

    logic [15:0]             lfsr;
    logic                    lfsr_fb;
    timer_phase_e            phase;
    logic [`PCX_PHASE_W-1:0] phase_cnt;
    logic [`PCX_PHASE_W-1:0] load_len;
    logic                    started;

    // Fibonacci feedback from taps 16, 14, 13 and 11
    assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    // Phase length for the next load, wraps at the counter width
    assign load_len = cfg.min_stall + (lfsr[`PCX_PHASE_W-1:0] & cfg.win_mask);

    // The LFSR runs whether or not random stalls are on
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr <= SEED;
        end else begin
            lfsr <= {lfsr[14:0], lfsr_fb};
        end
    end

    // A zero count ends the current phase and loads the length of the next one
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase     <= PH_FREE;
            phase_cnt <= '0;
            started   <= 1'b0;
        end else if (!cfg.rand_en) begin
            phase     <= PH_FREE;
            phase_cnt <= '0;
            started   <= 1'b0;
        end else if (phase_cnt == '0) begin
            phase_cnt <= load_len;
            started   <= 1'b1;
            if (!started) begin
                // First interval after enabling is always a free one
                phase <= PH_FREE;
            end else if (phase == PH_FREE) begin
                phase <= PH_STALL;
            end else begin
                phase <= PH_FREE;
            end
        end else begin
            phase_cnt <= phase_cnt - 1'b1;
        end
    end

    // Output follows the phase one cycle later and drops as soon as random stalls are off
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rand_stall <= 1'b0;
        end else begin
            rand_stall <= cfg.rand_en && (phase == PH_STALL);
        end
    end

endmodule

//--- logic/stall_gate.sv
// Stall combiner with queue-threshold gating and CAS1/CAS2 pair guard, driving the registered stalls
`timescale 1ns/1ps
`include "pcx_stall_config.svh"

module stall_gate
    import pcx_stall_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`PCX_NUM_DEST-1:0]  rand_stall,
    input  logic [`PCX_NUM_BANKS-1:0] held_stall,
    input  logic [`PCX_NUM_BANKS-1:0] cas1_grant,
    input  bank_qcnt_t                que_cnt,
    output logic [`PCX_NUM_BANKS-1:0] bank_stall,
    output logic                      fpu_stall
);

    logic [`PCX_NUM_BANKS-1:0] queue_ok;
    logic [`PCX_NUM_BANKS-1:0] raw;
    logic [`PCX_NUM_BANKS-1:0] raw_d1;
    logic [`PCX_NUM_BANKS-1:0] rising_on_cas1;

    // A bank is only stalled while its input queue has room, so the L2 keeps its own stall
    always_comb begin
        for (int i = 0; i < `PCX_NUM_BANKS; i++) begin
            queue_ok[i] = que_cnt[i] < `PCX_QCNT_W'(`PCX_IQ_THRESHOLD);
        end
    end

    assign raw = (rand_stall[`PCX_NUM_BANKS-1:0] | held_stall) & queue_ok;

    // A stall that would newly start under a CAS1 grant would split the CAS pair
    assign rising_on_cas1 = ~raw_d1 & cas1_grant;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            raw_d1 <= '0;
        end else begin
            raw_d1 <= raw;
        end
    end

    // FP1/FP2 may be separated, so the FPU stall is passed through unguarded
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bank_stall <= '0;
            fpu_stall  <= 1'b0;
        end else begin
            bank_stall <= raw & ~rising_on_cas1;
            fpu_stall  <= rand_stall[`PCX_NUM_DEST-1];
        end
    end

endmodule

//--- logic/pcx_stall_unit.sv
// Top level of the PCX stall injector joining command decode, five interval timers and the gate
`timescale 1ns/1ps
`include "pcx_stall_config.svh"

module pcx_stall_unit
    import pcx_stall_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cmd_valid,
    input  stall_cmd_t                cmd,
    input  logic [`PCX_NUM_BANKS-1:0] cas1_grant,
    input  bank_qcnt_t                que_cnt,
    output logic [`PCX_NUM_BANKS-1:0] bank_stall,
    output logic                      fpu_stall
);

    // Timer 4 serves the FPU/IOB destination, timers 0 to 3 the L2 banks
    localparam logic [`PCX_NUM_DEST-1:0][15:0] LFSR_SEEDS = {
        `PCX_LFSR_SEED4,
        `PCX_LFSR_SEED3,
        `PCX_LFSR_SEED2,
        `PCX_LFSR_SEED1,
        `PCX_LFSR_SEED0
    };

    logic [`PCX_NUM_BANKS-1:0] held_stall;
    stall_cfg_t                cfg;
    logic [`PCX_NUM_DEST-1:0]  rand_stall;

    stall_cmd_decode stall_cmd_decode_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .held_stall (held_stall),
        .cfg        (cfg)
    );

    for (genvar g = 0; g < `PCX_NUM_DEST; g++) begin : g_timer
        stall_interval_timer #(
            .SEED (LFSR_SEEDS[g])
        ) stall_interval_timer_i (
            .clk        (clk),
            .rst_n      (rst_n),
            .cfg        (cfg),
            .rand_stall (rand_stall[g])
        );
    end

    stall_gate stall_gate_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .rand_stall (rand_stall),
        .held_stall (held_stall),
        .cas1_grant (cas1_grant),
        .que_cnt    (que_cnt),
        .bank_stall (bank_stall),
        .fpu_stall  (fpu_stall)
    );

endmodule

//--- verif/pcx_stall_unit_properties.sv
// Concurrent checks on the stall outputs, bound into every instance of the stall unit top level
`timescale 1ns/1ps
`include "pcx_stall_config.svh"

module pcx_stall_unit_properties
    import pcx_stall_pkg::*;
(
    input logic                      clk,
    input logic                      rst_n,
    input logic [`PCX_NUM_BANKS-1:0] cas1_grant,
    input bank_qcnt_t                que_cnt,
    input logic [`PCX_NUM_BANKS-1:0] bank_stall,
    input logic                      fpu_stall
);

    for (genvar i = 0; i < `PCX_NUM_BANKS; i++) begin : g_bank
        // A low stall with no grant the cycle before means the request was low too,
        // so a fresh CAS1 grant must keep it low
        a_cas_pair: assert property (@(posedge clk) disable iff (!rst_n)
            !bank_stall[i] && cas1_grant[i] && !$past(cas1_grant[i]) |=> !bank_stall[i])
        else $error("bank %0d stall rose under a CAS1 grant", i);

        a_queue_full: assert property (@(posedge clk) disable iff (!rst_n)
            que_cnt[i] >= `PCX_QCNT_W'(`PCX_IQ_THRESHOLD) |=> !bank_stall[i])
        else $error("bank %0d stalled after its queue reached the threshold", i);
    end

    a_reset_low: assert property (@(posedge clk)
        !rst_n |=> (bank_stall == '0) && !fpu_stall)
    else $error("stall outputs not low after reset");

endmodule

bind pcx_stall_unit pcx_stall_unit_properties pcx_stall_unit_properties_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .cas1_grant (cas1_grant),
    .que_cnt    (que_cnt),
    .bank_stall (bank_stall),
    .fpu_stall  (fpu_stall)
);

//--- verif/pcx_stall_unit_tb.sv
// Self-checking testbench for the PCX stall injector, run as top with a cycle model and LFSR stimulus
`timescale 1ns/1ps
`include "pcx_stall_config.svh"

module pcx_stall_unit_tb
    import pcx_stall_pkg::*;
();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES  = 200;
    localparam int HELD_CYCLES  = 300;
    localparam int QUEUE_CYCLES = 300;
    localparam int CAS_CYCLES   = 300;
    localparam int RAND_ROUNDS  = 3;
    localparam int RAND_CYCLES  = 600;
    localparam int DRAIN_CYCLES = 20;
    localparam int TOTAL_CYCLES = RESET_CYCLES + IDLE_CYCLES + HELD_CYCLES + QUEUE_CYCLES
                                + CAS_CYCLES + RAND_ROUNDS * (RAND_CYCLES + DRAIN_CYCLES + 2) + 16;
    localparam int WATCHDOG_CYCLES = TOTAL_CYCLES + TOTAL_CYCLES / 4;

    localparam logic [15:0] TIMER_SEEDS [`PCX_NUM_DEST] = '{
        `PCX_LFSR_SEED0, `PCX_LFSR_SEED1, `PCX_LFSR_SEED2, `PCX_LFSR_SEED3, `PCX_LFSR_SEED4
    };

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      cmd_valid;
    stall_cmd_t                cmd;
    logic [`PCX_NUM_BANKS-1:0] cas1_grant;
    bank_qcnt_t                que_cnt;
    logic [`PCX_NUM_BANKS-1:0] bank_stall;
    logic                      fpu_stall;

    logic [31:0] rng_state  = 32'h83d3a897;
    logic        monitor_on = 1'b0;
    int          n_checks   = 0;
    int          bank_errs  = 0;
    int          fpu_errs   = 0;

    // Reference model state
    logic [`PCX_NUM_BANKS-1:0] m_held;
    logic                      m_rand_en;
    logic [`PCX_PHASE_W-1:0]   m_min;
    logic [`PCX_PHASE_W-1:0]   m_win;
    logic [15:0]               m_lfsr [`PCX_NUM_DEST];
    timer_phase_e              m_phase [`PCX_NUM_DEST];
    logic [`PCX_PHASE_W-1:0]   m_cnt [`PCX_NUM_DEST];
    logic [`PCX_NUM_DEST-1:0]  m_started;
    logic [`PCX_NUM_DEST-1:0]  m_rand;
    logic [`PCX_NUM_BANKS-1:0] m_raw_d1;
    logic [`PCX_NUM_BANKS-1:0] m_bank;
    logic                      m_fpu;

    pcx_stall_unit pcx_stall_unit_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cas1_grant (cas1_grant),
        .que_cnt    (que_cnt),
        .bank_stall (bank_stall),
        .fpu_stall  (fpu_stall)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // The 32-bit Fibonacci LFSR uses taps 32, 22, 2 and 1 and steps once per returned bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int k = 0; k < n; k++) begin
            fb        = rng_state[31] ^ rng_state[21] ^ rng_state[1] ^ rng_state[0];
            rng_state = {rng_state[30:0], fb};
            value     = {value[30:0], fb};
        end
        return value;
    endfunction

    // Every next state is computed from the current one, so the gate goes first and decode last
    task automatic model_step();
        logic [`PCX_NUM_BANKS-1:0] raw;
        logic [`PCX_PHASE_W-1:0]   len;
        logic                      fb;
        if (!rst_n) begin
            m_held    = '0;
            m_rand_en = 1'b0;
            m_min     = `PCX_MIN_STALL_RST;
            m_win     = `PCX_WIN_MASK_RST;
            m_started = '0;
            m_rand    = '0;
            m_raw_d1  = '0;
            m_bank    = '0;
            m_fpu     = 1'b0;
            for (int i = 0; i < `PCX_NUM_DEST; i++) begin
                m_lfsr[i]  = TIMER_SEEDS[i];
                m_phase[i] = PH_FREE;
                m_cnt[i]   = '0;
            end
        end else begin
            for (int i = 0; i < `PCX_NUM_BANKS; i++) begin
                raw[i] = (m_rand[i] | m_held[i])
                       & (que_cnt[i] < `PCX_QCNT_W'(`PCX_IQ_THRESHOLD));
            end
            m_bank   = raw & ~(~m_raw_d1 & cas1_grant);
            m_raw_d1 = raw;
            m_fpu    = m_rand[`PCX_NUM_DEST-1];
            for (int i = 0; i < `PCX_NUM_DEST; i++) begin
                m_rand[i] = m_rand_en && (m_phase[i] == PH_STALL);
                len       = m_min + (m_lfsr[i][`PCX_PHASE_W-1:0] & m_win);
                if (!m_rand_en) begin
                    m_phase[i]   = PH_FREE;
                    m_cnt[i]     = '0;
                    m_started[i] = 1'b0;
                end else if (m_cnt[i] == '0) begin
                    m_cnt[i] = len;
                    if (!m_started[i]) begin
                        m_phase[i] = PH_FREE;
                    end else begin
                        m_phase[i] = (m_phase[i] == PH_FREE) ? PH_STALL : PH_FREE;
                    end
                    m_started[i] = 1'b1;
                end else begin
                    m_cnt[i] = m_cnt[i] - 1'b1;
                end
                fb        = m_lfsr[i][15] ^ m_lfsr[i][13] ^ m_lfsr[i][12] ^ m_lfsr[i][10];
                m_lfsr[i] = {m_lfsr[i][14:0], fb};
            end
            if (cmd_valid) begin
                case (cmd.opcode)
                    OP_STALL_ON:   m_held = m_held | cmd.bank_mask;
                    OP_FREE_ON:    m_held = m_held & ~cmd.bank_mask;
                    OP_SET_WINDOW: begin
                        m_min = cmd.min_stall;
                        m_win = cmd.win_mask;
                    end
                    OP_RANDOM_EN:  m_rand_en = cmd.bank_mask[0];
                    default: begin
                    end
                endcase
            end
        end
    endtask

    task automatic check_bank(input logic [`PCX_NUM_BANKS-1:0] actual,
                              input logic [`PCX_NUM_BANKS-1:0] expected);
        n_checks++;
        if (actual !== expected) begin
            bank_errs++;
            $display("FAILED t=%0t bank_stall: got %b, expected %b", $time, actual, expected);
        end
    endtask

    task automatic check_fpu(input logic actual, input logic expected);
        n_checks++;
        if (actual !== expected) begin
            fpu_errs++;
            $display("FAILED t=%0t fpu_stall: got %b, expected %b", $time, actual, expected);
        end
    endtask

    always @(posedge clk) begin
        model_step();
    end

    // Outputs are compared on the falling edge, half a cycle after they change
    always @(negedge clk) begin
        if (monitor_on) begin
            check_bank(bank_stall, m_bank);
            check_fpu(fpu_stall, m_fpu);
        end
    end

    task automatic next_cycle();
        @(negedge clk);
        cmd_valid  = 1'b0;
        cmd        = '0;
        cas1_grant = '0;
    endtask

    task automatic send_cmd(input stall_opcode_e op, input logic [`PCX_NUM_BANKS-1:0] mask,
                            input logic [`PCX_PHASE_W-1:0] min_len,
                            input logic [`PCX_PHASE_W-1:0] win);
        next_cycle();
        cmd_valid     = 1'b1;
        cmd.opcode    = op;
        cmd.bank_mask = mask;
        cmd.min_stall = min_len;
        cmd.win_mask  = win;
    endtask

    task automatic set_low_queues();
        for (int b = 0; b < `PCX_NUM_BANKS; b++) begin
            que_cnt[b] = `PCX_QCNT_W'(rand_bits(3));
        end
    endtask

    task automatic idle_test();
        for (int k = 0; k < IDLE_CYCLES; k++) begin
            next_cycle();
            check_bank(bank_stall, '0);
            check_fpu(fpu_stall, 1'b0);
        end
    endtask

    task automatic held_test();
        for (int k = 0; k < HELD_CYCLES; k++) begin
            next_cycle();
            set_low_queues();
            if (rand_bits(1) == 32'd1) begin
                cmd_valid     = 1'b1;
                cmd.opcode    = (rand_bits(1) == 32'd1) ? OP_STALL_ON : OP_FREE_ON;
                cmd.bank_mask = `PCX_NUM_BANKS'(rand_bits(4));
            end
        end
        send_cmd(OP_FREE_ON, '1, '0, '0);
    endtask

    task automatic queue_test();
        send_cmd(OP_STALL_ON, '1, '0, '0);
        for (int k = 0; k < QUEUE_CYCLES; k++) begin
            next_cycle();
            for (int b = 0; b < `PCX_NUM_BANKS; b++) begin
                que_cnt[b] = `PCX_QCNT_W'(rand_bits(5));
            end
        end
        send_cmd(OP_FREE_ON, '1, '0, '0);
    endtask

    // Grants often land on the banks whose held state just changed
    task automatic cas_test();
        logic [`PCX_NUM_BANKS-1:0] prev_mask;
        prev_mask = '0;
        for (int k = 0; k < CAS_CYCLES; k++) begin
            next_cycle();
            set_low_queues();
            if (rand_bits(1) == 32'd1) begin
                cas1_grant = prev_mask;
            end else begin
                cas1_grant = `PCX_NUM_BANKS'(rand_bits(4)) & `PCX_NUM_BANKS'(rand_bits(4));
            end
            prev_mask = '0;
            if (rand_bits(2) == 32'd0) begin
                cmd_valid     = 1'b1;
                cmd.opcode    = (rand_bits(1) == 32'd1) ? OP_STALL_ON : OP_FREE_ON;
                cmd.bank_mask = `PCX_NUM_BANKS'(rand_bits(4));
                prev_mask     = cmd.bank_mask;
            end
        end
        send_cmd(OP_FREE_ON, '1, '0, '0);
    endtask

    task automatic random_test();
        logic [`PCX_PHASE_W-1:0] min_len;
        logic [`PCX_PHASE_W-1:0] win;
        min_len = `PCX_PHASE_W'(rand_bits(4));
        win     = `PCX_PHASE_W'(rand_bits(6));
        send_cmd(OP_SET_WINDOW, '0, min_len, win);
        send_cmd(OP_RANDOM_EN, `PCX_NUM_BANKS'(1), '0, '0);
        for (int k = 0; k < RAND_CYCLES; k++) begin
            next_cycle();
            for (int b = 0; b < `PCX_NUM_BANKS; b++) begin
                que_cnt[b] = `PCX_QCNT_W'(rand_bits(5));
            end
            cas1_grant = `PCX_NUM_BANKS'(rand_bits(4)) & `PCX_NUM_BANKS'(rand_bits(4));
        end
        send_cmd(OP_RANDOM_EN, '0, '0, '0);
        // Disable reaches the outputs three edges after the command
        for (int k = 0; k < DRAIN_CYCLES; k++) begin
            next_cycle();
            set_low_queues();
            if (k >= 2) begin
                check_bank(bank_stall, '0);
                check_fpu(fpu_stall, 1'b0);
            end
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        cmd_valid  = 1'b0;
        cmd        = '0;
        cas1_grant = '0;
        que_cnt    = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n      = 1'b1;
        monitor_on = 1'b1;
        idle_test();
        held_test();
        queue_test();
        cas_test();
        repeat (RAND_ROUNDS) random_test();
        next_cycle();
        $display("Checks: %0d, bank_stall errors: %0d, fpu_stall errors: %0d",
                 n_checks, bank_errs, fpu_errs);
        if (bank_errs + fpu_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- pcx_stall_unit.f
+incdir+logic
logic/pcx_stall_pkg.sv
logic/stall_cmd_decode.sv
logic/stall_interval_timer.sv
logic/stall_gate.sv
logic/pcx_stall_unit.sv
verif/pcx_stall_unit_properties.sv
verif/pcx_stall_unit_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = pcx_stall_unit_tb
FILELIST = pcx_stall_unit.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = *** FAILED ***
PASS_MSG = *** PASSED ***

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(wildcard logic/*.sv logic/*.svh verif/*.sv)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A run that stops before the pass message, such as on an assertion, also counts as failed
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; echo "Simulator exit status $$?" >> $(LOG)
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "Simulation incomplete, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
